/* Makefile */
# Verilator build and run for the cu_control testbench

VERILATOR ?= verilator
FLAGS     := --binary --timing -Wno-fatal -j 0
TOP       := cu_control_tb
FILELIST  := cu_control.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***

SOURCES := $(wildcard hdl/*.sv hdl/*.svh dv/*.sv)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log search decides pass or fail
run: compile
	./$(BINARY) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* cu_control.f */
+incdir+hdl
hdl/cu_pkg.sv
hdl/cmd_buf_if.sv
hdl/cmd_fifo.sv
hdl/array_fetch.sv
hdl/cmd_arbiter.sv
hdl/cu_control.sv
dv/cu_control_tb.sv

/* dv/cu_control_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cu_cfg.svh"

module cu_control_tb;

	localparam int NUM_JOBS     = 6;
	localparam int RESET_CYCLES = 3;
	localparam int SEQ_MOD      = 1 << (`CU_TAG_W - 1);

	typedef struct packed {
		logic [`CU_ADDR_W-1:0]  vertex_base;
		logic [`CU_COUNT_W-1:0] vertex_count;
		logic [`CU_ADDR_W-1:0]  edge_base;
		logic [`CU_COUNT_W-1:0] edge_count;
		logic                   back_pressure;
	} job_row;

	// vertex base, vertex count, edge base, edge count, random back-pressure
	localparam job_row JOBS [NUM_JOBS] = '{
		'{48'h0000_1000_0000, 32'd20,  48'h0000_2000_0000, 32'd40,  1'b0},
		'{48'h0000_0000_0080, 32'd5,   48'h7fff_0000_0000, 32'd0,   1'b0},
		// edge array wraps past the top of the address space
		'{48'h0000_3000_0000, 32'd0,   48'hffff_ffff_fc00, 32'd12,  1'b0},
		'{48'h0000_4000_0000, 32'd150, 48'h0000_5000_0000, 32'd140, 1'b1},
		'{48'h0000_6000_0000, 32'd1,   48'h0000_7000_0000, 32'd1,   1'b0},
		'{48'h0000_8000_0080, 32'd33,  48'h0000_9000_0000, 32'd64,  1'b1}
	};

	logic                   clock;
	logic                   rstn;
	logic                   job_start;
	logic [`CU_ADDR_W-1:0]  vertex_base;
	logic [`CU_COUNT_W-1:0] vertex_count;
	logic [`CU_ADDR_W-1:0]  edge_base;
	logic [`CU_COUNT_W-1:0] edge_count;
	logic                   read_buffer_alfull;
	logic                   read_response_valid;
	logic [`CU_TAG_W-1:0]   read_response_tag;
	logic                   read_command_valid;
	logic [`CU_ADDR_W-1:0]  read_command_address;
	logic [`CU_SIZE_W-1:0]  read_command_size;
	logic [`CU_TAG_W-1:0]   read_command_tag;
	logic                   job_done;

	// 0 before the first job, 1 running, 2 job_done seen
	int phase = 0;
	int job_cycle = 0;
	int cycle = 0;

	// scoreboard, indexed by source id
	logic [`CU_ADDR_W-1:0] base_of [2];
	int                    count_of [2];
	int                    next_idx [2];
	cu_pkg::source_id      last_src = cu_pkg::SRC_VERTEX;
	logic                  bp_enable = 1'b0;
	int                    bp_hold = 0;
	int                    bp_leaked = 0;

	// response model queues
	logic [`CU_TAG_W-1:0] vertex_tags [$];
	int                   vertex_due [$];
	logic [`CU_TAG_W-1:0] edge_tags [$];
	int                   edge_due [$];
	int                   vertex_last_due = 0;
	int                   edge_last_due = 0;
	logic                 resp_turn = 1'b0;
	int                   responses_given = 0;
	int                   responses_total = 0;

	cu_control i_dut (
		.clock                (clock),
		.rstn                 (rstn),
		.job_start            (job_start),
		.vertex_base          (vertex_base),
		.vertex_count         (vertex_count),
		.edge_base            (edge_base),
		.edge_count           (edge_count),
		.read_buffer_alfull   (read_buffer_alfull),
		.read_response_valid  (read_response_valid),
		.read_response_tag    (read_response_tag),
		.read_command_valid   (read_command_valid),
		.read_command_address (read_command_address),
		.read_command_size    (read_command_size),
		.read_command_tag     (read_command_tag),
		.job_done             (job_done)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	task automatic check(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected) begin
			$display("Fail %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			$display("*** TEST FAILED ***");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

////////////////////////////////////////////////////////////
// scoreboard and response model
////////////////////////////////////////////////////////////

	task automatic observe_command();
		cu_pkg::source_id      src;
		int                    s;
		int                    idx;
		int                    due;
		logic [`CU_ADDR_W-1:0] exp_address;
		logic [`CU_TAG_W-1:0]  exp_tag;
		src = cu_pkg::source_id'(read_command_tag[`CU_TAG_W-1]);
		s = int'(src);
		idx = next_idx[s];
		check("read_command_tag index below count", idx < count_of[s], 1);
		exp_address = base_of[s] + `CU_ADDR_W'(idx) * `CU_ADDR_W'(`CU_LINE_BYTES);
		exp_tag = `CU_TAG_W'(s * SEQ_MOD + idx % SEQ_MOD);
		check("read_command_address", read_command_address, exp_address);
		check("read_command_size", read_command_size, `CU_LINE_BYTES);
		check("read_command_tag", read_command_tag, exp_tag);
		// strict alternation while both sources still have lines
		if (!bp_enable && next_idx[0] > 0 && next_idx[1] > 0
				&& next_idx[0] < count_of[0] && next_idx[1] < count_of[1]) begin
			check("read_command_tag source bit", s, int'(last_src) ^ 1);
		end
		last_src = src;
		next_idx[s] = idx + 1;
		// in order per source, so never earlier than the previous one
		due = cycle + int'($urandom_range(1, 8));
		if (s == 0) begin
			if (due < vertex_last_due) begin
				due = vertex_last_due;
			end
			vertex_last_due = due;
			vertex_tags.push_back(read_command_tag);
			vertex_due.push_back(due);
		end else begin
			if (due < edge_last_due) begin
				due = edge_last_due;
			end
			edge_last_due = due;
			edge_tags.push_back(read_command_tag);
			edge_due.push_back(due);
		end
	endtask

	task automatic check_job_state();
		case (phase)
			0: begin
				check("read_command_valid", read_command_valid, 0);
				check("job_done", job_done, 0);
			end
			1: begin
				job_cycle = job_cycle + 1;
				// old job_done drains through the pipeline first
				if (job_cycle >= 3 && job_done) begin
					check("job_done responses given", responses_given, responses_total);
					phase = 2;
				end
			end
			default: begin
				check("job_done", job_done, 1);
			end
		endcase
	endtask

	task automatic drive_response();
		logic vertex_ready;
		logic edge_ready;
		vertex_ready = (vertex_due.size() > 0) && (vertex_due[0] <= cycle);
		edge_ready = (edge_due.size() > 0) && (edge_due[0] <= cycle);
		read_response_valid = 1'b0;
		if (vertex_ready && (!edge_ready || !resp_turn)) begin
			read_response_tag = vertex_tags.pop_front();
			void'(vertex_due.pop_front());
			read_response_valid = 1'b1;
			resp_turn = 1'b1;
		end else if (edge_ready) begin
			read_response_tag = edge_tags.pop_front();
			void'(edge_due.pop_front());
			read_response_valid = 1'b1;
			resp_turn = 1'b0;
		end
		if (read_response_valid) begin
			responses_given = responses_given + 1;
		end
	endtask

	task automatic drive_backpressure();
		if (read_buffer_alfull) begin
			bp_hold = bp_hold - 1;
			if (bp_hold <= 0) begin
				read_buffer_alfull = 1'b0;
			end
		end else if (bp_enable && phase == 1 && $urandom_range(0, 11) == 0) begin
			read_buffer_alfull = 1'b1;
			bp_hold = int'($urandom_range(3, 15));
			bp_leaked = 0;
		end
	endtask

	// samples outputs first, then drives responses and back-pressure
	initial begin : response_model
		void'($urandom(92));
		read_buffer_alfull = 1'b0;
		read_response_valid = 1'b0;
		read_response_tag = '0;
		forever begin
			@(negedge clock);
			cycle = cycle + 1;
			if (cycle > RESET_CYCLES) begin
				check_job_state();
				if (read_buffer_alfull && read_command_valid) begin
					bp_leaked = bp_leaked + 1;
					check("read_command_valid under almost-full", bp_leaked <= 3, 1);
				end
				if (read_command_valid) begin
					observe_command();
				end
				drive_response();
				drive_backpressure();
			end
		end
	end

////////////////////////////////////////////////////////////
// job sequence
////////////////////////////////////////////////////////////

	task automatic run_job(input job_row row);
		vertex_base = row.vertex_base;
		vertex_count = row.vertex_count;
		edge_base = row.edge_base;
		edge_count = row.edge_count;
		job_start = 1'b1;
		@(posedge clock);
		base_of[0] = row.vertex_base;
		base_of[1] = row.edge_base;
		count_of[0] = int'(row.vertex_count);
		count_of[1] = int'(row.edge_count);
		next_idx[0] = 0;
		next_idx[1] = 0;
		responses_given = 0;
		responses_total = count_of[0] + count_of[1];
		bp_enable = row.back_pressure;
		job_cycle = 0;
		phase = 1;
		@(negedge clock);
		job_start = 1'b0;
		do begin
			@(posedge clock);
		end while (phase != 2);
		check("vertex commands issued", next_idx[0], count_of[0]);
		check("edge commands issued", next_idx[1], count_of[1]);
		// job_done must hold during the gap
		repeat (8) @(negedge clock);
	endtask

	initial begin : main_sequence
		rstn = 1'b0;
		job_start = 1'b0;
		vertex_base = '0;
		vertex_count = '0;
		edge_base = '0;
		edge_count = '0;
		repeat (RESET_CYCLES) @(negedge clock);
		rstn = 1'b1;
		repeat (6) @(negedge clock);
		for (int i = 0; i < NUM_JOBS; i++) begin
			run_job(JOBS[i]);
		end
		$display("*** TEST PASSED ***");
		$finish;
	end

	// 40 cycles per cacheline plus slack for reset and gaps
	initial begin : watchdog
		int unsigned lines;
		lines = 0;
		for (int i = 0; i < NUM_JOBS; i++) begin
			lines = lines + JOBS[i].vertex_count + JOBS[i].edge_count;
		end
		repeat (40 * lines + 200) @(posedge clock);
		$display("Timeout: the job table did not finish within %0d cycles", 40 * lines + 200);
		$display("*** TEST FAILED ***");
		$fatal(1, "run timed out");
	end

endmodule

`default_nettype wire

/* hdl/array_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cu_cfg.svh"

module array_fetch #(
	parameter cu_pkg::source_id SRC = cu_pkg::SRC_VERTEX
) (
	input  wire logic                    clock,
	input  wire logic                    rstn,
	input  wire logic                    job_start,
	input  wire logic [`CU_ADDR_W-1:0]   base,
	input  wire logic [`CU_COUNT_W-1:0]  count,
	input  wire logic                    buf_alfull,
	output cu_pkg::command_line          command_out,
	input  wire cu_pkg::read_response    response_in,
	output logic                         done
);

	localparam logic [`CU_ADDR_W-1:0] LINE_STEP = `CU_ADDR_W'(`CU_LINE_BYTES);
	localparam logic [`CU_SIZE_W-1:0] LINE_SIZE = `CU_SIZE_W'(`CU_LINE_BYTES);

	// set by the first job_start, so nothing reads as done out of reset
	logic                   armed;
	logic [`CU_COUNT_W-1:0] count_q;
	logic [`CU_COUNT_W-1:0] issued;
	logic [`CU_COUNT_W-1:0] answered;
	logic [`CU_ADDR_W-1:0]  next_address;
	logic                   issue;
	logic                   own_response;

	// stall whenever our buffer reports almost full
	assign issue = armed & (issued < count_q) & ~buf_alfull;

	// only responses tagged with our source id
	assign own_response = response_in.valid & (cu_pkg::tag_source(response_in.tag) == SRC);

	// zero count is done right after the start
	assign done = armed & (issued == count_q) & (answered == count_q);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			armed    <= 1'b0;
			count_q  <= '0;
			issued   <= '0;
			answered <= '0;
		end else if (job_start) begin
			armed    <= 1'b1;
			count_q  <= count;
			issued   <= '0;
			answered <= '0;
		end else begin
			if (issue) begin
				issued <= issued + 1'b1;
			end
			if (own_response) begin
				answered <= answered + 1'b1;
			end
		end
	end

	// address of the next line to request
	always_ff @(posedge clock) begin
		if (job_start) begin
			next_address <= base;
		end else if (issue) begin
			next_address <= next_address + LINE_STEP;
		end
	end

	// registered command, valid bit is the buffer push
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			command_out <= '0;
		end else begin
			command_out <= '{
				valid:   issue,
				address: next_address,
				size:    LINE_SIZE,
				tag:     cu_pkg::make_tag(SRC, issued[cu_pkg::SEQ_W-1:0])
			};
		end
	end

endmodule

`default_nettype wire

/* hdl/cmd_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_arbiter #(
	parameter int NUM_REQUESTS = 2
) (
	input  wire logic           clock,
	input  wire logic           rstn,
	input  wire logic           downstream_alfull,
	cmd_buf_if.arbiter          ports [NUM_REQUESTS],
	output cu_pkg::command_line command_out
);

	localparam int IDX_W = (NUM_REQUESTS > 1) ? $clog2(NUM_REQUESTS) : 1;

	logic [NUM_REQUESTS-1:0] eligible;
	logic [NUM_REQUESTS-1:0] grant;
	logic [IDX_W-1:0]        grant_idx;
	logic [IDX_W-1:0]        prio;
	logic                    any_grant;
	cu_pkg::command_line     lines [NUM_REQUESTS];

	// flatten the interface array, pop in the grant cycle
	for (genvar i = 0; i < NUM_REQUESTS; i++) begin : g_port
		assign eligible[i] = ~ports[i].empty & ~downstream_alfull;
		assign lines[i]    = ports[i].command;
		assign ports[i].pop = grant[i];
	end

	// first eligible requester starting at the priority pointer
	always_comb begin
		int idx;
		grant     = '0;
		grant_idx = '0;
		any_grant = 1'b0;
		for (int k = 0; k < NUM_REQUESTS; k++) begin
			idx = (int'(prio) + k) % NUM_REQUESTS;
			if (!any_grant && eligible[idx]) begin
				grant[idx] = 1'b1;
				grant_idx  = IDX_W'(idx);
				any_grant  = 1'b1;
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			prio        <= '0;
			command_out <= '0;
		end else begin
			// pointer moves past the winner so busy buffers alternate
			if (any_grant) begin
				prio <= (grant_idx == IDX_W'(NUM_REQUESTS - 1)) ? '0 : grant_idx + 1'b1;
			end
			command_out       <= lines[grant_idx];
			command_out.valid <= any_grant;
		end
	end

endmodule

`default_nettype wire

/* hdl/cmd_buf_if.sv */
`timescale 1ns/1ps
`default_nettype none

// show-ahead buffer head towards the arbiter
interface cmd_buf_if #(
	parameter type payload_t = cu_pkg::command_line
);

	// head entry, meaningful while empty is low
	payload_t command;
	logic     empty;
	logic     alfull;
	// removes the head at the clock edge
	logic     pop;

	modport buffer (
		output command,
		output empty,
		output alfull,
		input  pop
	);

	modport arbiter (
		input  command,
		input  empty,
		input  alfull,
		output pop
	);

endinterface

`default_nettype wire

/* hdl/cmd_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cu_cfg.svh"

module cmd_fifo #(
	parameter type payload_t = cu_pkg::command_line,
	parameter int  DEPTH     = 16
) (
	input  wire logic     clock,
	input  wire logic     rstn,
	input  wire logic     push,
	input  wire payload_t data_in,
	output logic          full,
	output logic          alfull,
	cmd_buf_if.buffer     buf_port
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	cu_pkg::buffer_status status;

	// flags straight from the occupancy count
	assign status.full   = (count == CNT_W'(DEPTH));
	assign status.alfull = (count >= CNT_W'(DEPTH - `CU_ALFULL_MARGIN));
	assign status.empty  = (count == '0);
	assign status.valid  = ~status.empty;

	// push into a full buffer is dropped
	assign do_push = push & ~status.full;
	assign do_pop  = buf_port.pop & status.valid;

	assign full             = status.full;
	assign alfull           = status.alfull;
	assign buf_port.empty   = status.empty;
	assign buf_port.alfull  = status.alfull;
	// show-ahead head
	assign buf_port.command = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// simultaneous push and pop leaves the count alone
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/cu_cfg.svh */
`ifndef CU_CFG_SVH
`define CU_CFG_SVH

// host byte address
`define CU_ADDR_W 48

// command tag, top bit is the source id, the rest a wrapping sequence number
`define CU_TAG_W 8

// size field of a command line
`define CU_SIZE_W 12

// cacheline counts per array
`define CU_COUNT_W 32

// one cacheline per read command
`define CU_LINE_BYTES 128

// per-engine command buffer depths
`define CU_VERTEX_BUF_DEPTH 16
`define CU_EDGE_BUF_DEPTH 32

// free slots left when almost-full asserts
`define CU_ALFULL_MARGIN 4

`endif

/* hdl/cu_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cu_cfg.svh"

module cu_control (
	input  wire logic                   clock,
	input  wire logic                   rstn,
	input  wire logic                   job_start,
	input  wire logic [`CU_ADDR_W-1:0]  vertex_base,
	input  wire logic [`CU_COUNT_W-1:0] vertex_count,
	input  wire logic [`CU_ADDR_W-1:0]  edge_base,
	input  wire logic [`CU_COUNT_W-1:0] edge_count,
	input  wire logic                   read_buffer_alfull,
	input  wire logic                   read_response_valid,
	input  wire logic [`CU_TAG_W-1:0]   read_response_tag,
	output logic                        read_command_valid,
	output logic [`CU_ADDR_W-1:0]       read_command_address,
	output logic [`CU_SIZE_W-1:0]       read_command_size,
	output logic [`CU_TAG_W-1:0]        read_command_tag,
	output logic                        job_done
);

	// index 0 vertex, index 1 edge
	localparam int NUM_REQUESTS = 2;

	// latched inputs
	logic                   job_start_q;
	logic [`CU_ADDR_W-1:0]  vertex_base_q;
	logic [`CU_COUNT_W-1:0] vertex_count_q;
	logic [`CU_ADDR_W-1:0]  edge_base_q;
	logic [`CU_COUNT_W-1:0] edge_count_q;
	logic                   read_buffer_alfull_q;
	cu_pkg::read_response   read_response_q;

	// engines to buffers
	cu_pkg::command_line vertex_command;
	cu_pkg::command_line edge_command;
	logic                vertex_buf_alfull;
	logic                edge_buf_alfull;
	logic                vertex_done;
	logic                edge_done;

	cu_pkg::command_line arbiter_out;
	cu_pkg::command_line read_command_q;

	cmd_buf_if buf_ports [NUM_REQUESTS] ();

////////////////////////////////////////////////////////////
// input and output register stages
////////////////////////////////////////////////////////////

	// outside buffer reads as almost full until the first sample
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_start_q          <= 1'b0;
			read_buffer_alfull_q <= 1'b1;
			read_response_q      <= '0;
		end else begin
			job_start_q          <= job_start;
			read_buffer_alfull_q <= read_buffer_alfull;
			read_response_q      <= '{valid: read_response_valid, tag: read_response_tag};
		end
	end

	// job parameters
	always_ff @(posedge clock) begin
		vertex_base_q  <= vertex_base;
		vertex_count_q <= vertex_count;
		edge_base_q    <= edge_base;
		edge_count_q   <= edge_count;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_command_q <= '0;
			job_done       <= 1'b0;
		end else begin
			read_command_q <= arbiter_out;
			job_done       <= vertex_done & edge_done;
		end
	end

	assign read_command_valid   = read_command_q.valid;
	assign read_command_address = read_command_q.address;
	assign read_command_size    = read_command_q.size;
	assign read_command_tag     = read_command_q.tag;

////////////////////////////////////////////////////////////
// fetch engines
////////////////////////////////////////////////////////////

	array_fetch #(
		.SRC(cu_pkg::SRC_VERTEX)
	) i_vertex_fetch (
		.clock       (clock),
		.rstn        (rstn),
		.job_start   (job_start_q),
		.base        (vertex_base_q),
		.count       (vertex_count_q),
		.buf_alfull  (vertex_buf_alfull),
		.command_out (vertex_command),
		.response_in (read_response_q),
		.done        (vertex_done)
	);

	array_fetch #(
		.SRC(cu_pkg::SRC_EDGE)
	) i_edge_fetch (
		.clock       (clock),
		.rstn        (rstn),
		.job_start   (job_start_q),
		.base        (edge_base_q),
		.count       (edge_count_q),
		.buf_alfull  (edge_buf_alfull),
		.command_out (edge_command),
		.response_in (read_response_q),
		.done        (edge_done)
	);

////////////////////////////////////////////////////////////
// command buffers
////////////////////////////////////////////////////////////

	cmd_fifo #(
		.payload_t (cu_pkg::command_line),
		.DEPTH     (`CU_VERTEX_BUF_DEPTH)
	) i_vertex_buf (
		.clock    (clock),
		.rstn     (rstn),
		.push     (vertex_command.valid),
		.data_in  (vertex_command),
		.full     (),
		.alfull   (vertex_buf_alfull),
		.buf_port (buf_ports[0])
	);

	cmd_fifo #(
		.payload_t (cu_pkg::command_line),
		.DEPTH     (`CU_EDGE_BUF_DEPTH)
	) i_edge_buf (
		.clock    (clock),
		.rstn     (rstn),
		.push     (edge_command.valid),
		.data_in  (edge_command),
		.full     (),
		.alfull   (edge_buf_alfull),
		.buf_port (buf_ports[1])
	);

////////////////////////////////////////////////////////////
// arbitration onto the shared read port
////////////////////////////////////////////////////////////

	cmd_arbiter #(
		.NUM_REQUESTS(NUM_REQUESTS)
	) i_arbiter (
		.clock             (clock),
		.rstn              (rstn),
		.downstream_alfull (read_buffer_alfull_q),
		.ports             (buf_ports),
		.command_out       (arbiter_out)
	);

endmodule

`default_nettype wire

/* hdl/cu_pkg.sv */
`default_nettype none

`include "cu_cfg.svh"

package cu_pkg;

	// sequence part of a tag
	localparam int SEQ_W = `CU_TAG_W - 1;

	// which engine a command or response belongs to
	typedef enum logic {
		SRC_VERTEX = 1'b0,
		SRC_EDGE   = 1'b1
	} source_id;

	// one read command towards the host
	typedef struct packed {
		logic                   valid;
		logic [`CU_ADDR_W-1:0]  address;
		logic [`CU_SIZE_W-1:0]  size;
		logic [`CU_TAG_W-1:0]   tag;
	} command_line;

	// read response, data not carried here
	typedef struct packed {
		logic                 valid;
		logic [`CU_TAG_W-1:0] tag;
	} read_response;

	// buffer flags, same field order as the host side status
	typedef struct packed {
		logic valid;
		logic empty;
		logic alfull;
		logic full;
	} buffer_status;

	// source bit on top, sequence number below
	function automatic logic [`CU_TAG_W-1:0] make_tag(source_id src, logic [SEQ_W-1:0] seq);
		return {1'(src), seq};
	endfunction

	function automatic source_id tag_source(logic [`CU_TAG_W-1:0] tag);
		return source_id'(tag[`CU_TAG_W-1]);
	endfunction

endpackage

`default_nettype wire
